//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = tb_rv_core
FILELIST  = tb.f

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q '^TEST PASS$$'

clean:
	rm -rf obj_dir

//--- source/rv_core.sv
`timescale 1ns/10ps

module rv_core (
  input  logic                   clk,
  input  logic                   nrst,
  input  rv_core_pkg::word_t     i_wb_dat,
  input  logic                   i_wb_ack,
  input  logic                   i_halt_req,
  input  logic                   i_resume_req,
  input  rv_core_pkg::word_t     i_resume_pc,
  output logic                   o_wb_cyc,
  output logic                   o_wb_stb,
  output rv_core_pkg::word_t     o_wb_adr,
  output logic                   o_halted,
  output logic                   o_retire_valid,
  output rv_core_pkg::word_t     o_retire_pc,
  output logic                   o_retire_we,
  output rv_core_pkg::reg_addr_t o_retire_rd,
  output rv_core_pkg::word_t     o_retire_data
);

  logic running;
  logic resume;
  logic f_valid;
  logic d_ready;
  rv_core_pkg::word_t f_inst;
  rv_core_pkg::word_t f_pc;
  rv_core_pkg::reg_addr_t rs1_addr;
  rv_core_pkg::reg_addr_t rs2_addr;
  rv_core_pkg::word_t rs1_data;
  rv_core_pkg::word_t rs2_data;
  logic rs1_busy;
  logic rs2_busy;
  logic set_busy;
  rv_core_pkg::reg_addr_t busy_addr;
  logic x_valid;
  rv_core_pkg::word_t x_pc;
  rv_core_pkg::word_t x_inst;
  rv_core_pkg::word_t x_imm;
  rv_core_pkg::word_t x_src1;
  rv_core_pkg::word_t x_src2;
  rv_core_pkg::word_t x_rs1;
  rv_core_pkg::alu_op_t x_alu_op;
  logic x_alt;
  logic flush;
  rv_core_pkg::word_t target;

  assign o_halted = ~running;
  assign resume = ~running & i_resume_req;

  always_ff @(posedge clk) begin
    if (!nrst) begin
      running <= 1'b0;
    end else if (resume) begin
      running <= 1'b1;
    end else if (i_halt_req) begin
      running <= 1'b0;
    end
  end

  // halt request blocks new fetches in its own cycle
  rv_fetch i_fetch (
    .clk(clk), .nrst(nrst), .i_running(running & ~i_halt_req),
    .i_resume(resume), .i_resume_pc(i_resume_pc), .i_flush(flush), .i_target(target),
    .i_wb_dat(i_wb_dat), .i_wb_ack(i_wb_ack), .i_d_ready(d_ready),
    .o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_adr(o_wb_adr),
    .o_f_valid(f_valid), .o_f_inst(f_inst), .o_f_pc(f_pc)
  );

  rv_decode i_decode (
    .clk(clk), .nrst(nrst), .i_f_valid(f_valid), .i_f_inst(f_inst), .i_f_pc(f_pc),
    .i_flush(flush), .i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
    .i_rs1_busy(rs1_busy), .i_rs2_busy(rs2_busy), .o_d_ready(d_ready),
    .o_rs1_addr(rs1_addr), .o_rs2_addr(rs2_addr), .o_set_busy(set_busy),
    .o_busy_addr(busy_addr), .o_x_valid(x_valid), .o_x_pc(x_pc), .o_x_inst(x_inst),
    .o_x_imm(x_imm), .o_x_src1(x_src1), .o_x_src2(x_src2), .o_x_rs1(x_rs1),
    .o_x_alu_op(x_alu_op), .o_x_alt(x_alt)
  );

  rv_regfile i_regfile (
    .clk(clk), .nrst(nrst), .i_rs1_addr(rs1_addr), .i_rs2_addr(rs2_addr),
    .i_set_busy(set_busy), .i_busy_addr(busy_addr), .i_wb_en(o_retire_we),
    .i_wb_addr(o_retire_rd), .i_wb_data(o_retire_data), .o_rs1_data(rs1_data),
    .o_rs2_data(rs2_data), .o_rs1_busy(rs1_busy), .o_rs2_busy(rs2_busy)
  );

  rv_execute i_execute (
    .clk(clk), .nrst(nrst), .i_x_valid(x_valid), .i_x_pc(x_pc), .i_x_inst(x_inst),
    .i_x_imm(x_imm), .i_x_src1(x_src1), .i_x_src2(x_src2), .i_x_rs1(x_rs1),
    .i_x_alu_op(x_alu_op), .i_x_alt(x_alt), .o_flush(flush), .o_target(target),
    .o_wb_en(o_retire_we), .o_wb_addr(o_retire_rd), .o_wb_data(o_retire_data),
    .o_retire_valid(o_retire_valid), .o_retire_pc(o_retire_pc)
  );

endmodule

//--- source/rv_core_pkg.sv
package rv_core_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;
  localparam int n_regs = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;
  typedef logic [4:0] opcode_t;
  typedef logic [2:0] alu_op_t;

  // major opcodes, inst[6:2]
  localparam opcode_t opcode_op = 5'b01100;
  localparam opcode_t opcode_op_imm = 5'b00100;
  localparam opcode_t opcode_lui = 5'b01101;
  localparam opcode_t opcode_auipc = 5'b00101;
  localparam opcode_t opcode_branch = 5'b11000;
  localparam opcode_t opcode_jal = 5'b11011;
  localparam opcode_t opcode_jalr = 5'b11001;

  // alu functions, same encoding as funct3
  localparam alu_op_t funct3_add = 3'b000;
  localparam alu_op_t funct3_sll = 3'b001;
  localparam alu_op_t funct3_slt = 3'b010;
  localparam alu_op_t funct3_sltu = 3'b011;
  localparam alu_op_t funct3_xor = 3'b100;
  localparam alu_op_t funct3_sr = 3'b101;
  localparam alu_op_t funct3_or = 3'b110;
  localparam alu_op_t funct3_and = 3'b111;

  // branch conditions
  localparam logic [2:0] funct3_beq = 3'b000;
  localparam logic [2:0] funct3_bne = 3'b001;
  localparam logic [2:0] funct3_blt = 3'b100;
  localparam logic [2:0] funct3_bge = 3'b101;
  localparam logic [2:0] funct3_bltu = 3'b110;
  localparam logic [2:0] funct3_bgeu = 3'b111;

  localparam word_t reset_pc = '0;

  // true for the kept opcodes that produce a register result
  function automatic logic writes_rd(opcode_t op);
    logic res;
    case (op)
      opcode_op,
      opcode_op_imm,
      opcode_lui,
      opcode_auipc,
      opcode_jal,
      opcode_jalr: res = 1'b1;
      default: res = 1'b0;
    endcase
    return res;
  endfunction

endpackage

//--- source/rv_decode.sv
`timescale 1ns/10ps

module rv_decode (
  input  logic                       clk,
  input  logic                       nrst,
  input  logic                       i_f_valid,
  input  rv_core_pkg::word_t         i_f_inst,
  input  rv_core_pkg::word_t         i_f_pc,
  input  logic                       i_flush,
  input  rv_core_pkg::word_t         i_rs1_data,
  input  rv_core_pkg::word_t         i_rs2_data,
  input  logic                       i_rs1_busy,
  input  logic                       i_rs2_busy,
  output logic                       o_d_ready,
  output rv_core_pkg::reg_addr_t     o_rs1_addr,
  output rv_core_pkg::reg_addr_t     o_rs2_addr,
  output logic                       o_set_busy,
  output rv_core_pkg::reg_addr_t     o_busy_addr,
  output logic                       o_x_valid,
  output rv_core_pkg::word_t         o_x_pc,
  output rv_core_pkg::word_t         o_x_inst,
  output rv_core_pkg::word_t         o_x_imm,
  output rv_core_pkg::word_t         o_x_src1,
  output rv_core_pkg::word_t         o_x_src2,
  output rv_core_pkg::word_t         o_x_rs1,
  output rv_core_pkg::alu_op_t       o_x_alu_op,
  output logic                       o_x_alt
);

  rv_core_pkg::opcode_t opcode;
  logic [2:0] funct3;
  rv_core_pkg::reg_addr_t rd;
  rv_core_pkg::reg_addr_t x_rd;
  rv_core_pkg::word_t imm;
  rv_core_pkg::word_t src1;
  rv_core_pkg::word_t src2;
  rv_core_pkg::alu_op_t alu_op;
  logic alt;
  logic use_rs1;
  logic use_rs2;
  logic has_rd;
  logic stall;
  logic issue;

  assign opcode = i_f_inst[6:2];
  assign funct3 = i_f_inst[14:12];
  assign rd = i_f_inst[11:7];
  assign o_rs1_addr = i_f_inst[19:15];
  assign o_rs2_addr = i_f_inst[24:20];

  assign has_rd = rv_core_pkg::writes_rd(opcode) && (rd != '0);
  assign use_rs1 = opcode inside {rv_core_pkg::opcode_op, rv_core_pkg::opcode_op_imm,
                                  rv_core_pkg::opcode_branch, rv_core_pkg::opcode_jalr};
  assign use_rs2 = opcode inside {rv_core_pkg::opcode_op, rv_core_pkg::opcode_branch};

  // raw on a busy source, or waw against the writer still in execute;
  // busy bit alone would be cleared early by an older writeback
  assign stall = i_f_valid & ((use_rs1 & i_rs1_busy) | (use_rs2 & i_rs2_busy) |
                              (has_rd & (x_rd == rd)));
  assign o_d_ready = ~stall;
  assign issue = i_f_valid & ~stall & ~i_flush;
  assign o_set_busy = issue & has_rd;
  assign o_busy_addr = rd;

  always_comb begin
    case (opcode)
      rv_core_pkg::opcode_lui,
      rv_core_pkg::opcode_auipc: imm = {i_f_inst[31:12], 12'h000};
      rv_core_pkg::opcode_jal: imm = {{12{i_f_inst[31]}}, i_f_inst[19:12], i_f_inst[20],
                                      i_f_inst[30:21], 1'b0};
      rv_core_pkg::opcode_branch: imm = {{20{i_f_inst[31]}}, i_f_inst[7], i_f_inst[30:25],
                                         i_f_inst[11:8], 1'b0};
      default: imm = {{20{i_f_inst[31]}}, i_f_inst[31:20]};
    endcase
  end

  always_comb begin
    if (opcode == rv_core_pkg::opcode_lui) begin
      src1 = '0;
    end else if (opcode inside {rv_core_pkg::opcode_auipc, rv_core_pkg::opcode_jal}) begin
      src1 = i_f_pc;
    end else begin
      src1 = i_rs1_data;
    end
    src2 = use_rs2 ? i_rs2_data : imm;
  end

  always_comb begin
    alu_op = rv_core_pkg::funct3_add;
    alt = 1'b0;
    if (opcode inside {rv_core_pkg::opcode_op, rv_core_pkg::opcode_op_imm}) begin
      alu_op = funct3;
      // sub only on OP, sra on both
      if (opcode == rv_core_pkg::opcode_op || funct3 == rv_core_pkg::funct3_sr) begin
        alt = i_f_inst[30];
      end
    end else if (opcode == rv_core_pkg::opcode_branch) begin
      if (funct3 inside {rv_core_pkg::funct3_beq, rv_core_pkg::funct3_bne}) begin
        alu_op = rv_core_pkg::funct3_xor;
      end else if (funct3 inside {rv_core_pkg::funct3_blt, rv_core_pkg::funct3_bge}) begin
        alu_op = rv_core_pkg::funct3_slt;
      end else begin
        alu_op = rv_core_pkg::funct3_sltu;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      o_x_valid <= 1'b0;
      x_rd <= '0;
    end else begin
      o_x_valid <= issue;
      x_rd <= o_set_busy ? rd : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      o_x_pc <= i_f_pc;
      o_x_inst <= i_f_inst;
      o_x_imm <= imm;
      o_x_src1 <= src1;
      o_x_src2 <= src2;
      o_x_rs1 <= i_rs1_data;
      o_x_alu_op <= alu_op;
      o_x_alt <= alt;
    end
  end

endmodule

//--- source/rv_execute.sv
`timescale 1ns/10ps

module rv_execute (
  input  logic                   clk,
  input  logic                   nrst,
  input  logic                   i_x_valid,
  input  rv_core_pkg::word_t     i_x_pc,
  input  rv_core_pkg::word_t     i_x_inst,
  input  rv_core_pkg::word_t     i_x_imm,
  input  rv_core_pkg::word_t     i_x_src1,
  input  rv_core_pkg::word_t     i_x_src2,
  input  rv_core_pkg::word_t     i_x_rs1,
  input  rv_core_pkg::alu_op_t   i_x_alu_op,
  input  logic                   i_x_alt,
  output logic                   o_flush,
  output rv_core_pkg::word_t     o_target,
  output logic                   o_wb_en,
  output rv_core_pkg::reg_addr_t o_wb_addr,
  output rv_core_pkg::word_t     o_wb_data,
  output logic                   o_retire_valid,
  output rv_core_pkg::word_t     o_retire_pc
);

  rv_core_pkg::opcode_t opcode;
  logic [2:0] funct3;
  rv_core_pkg::reg_addr_t rd;
  rv_core_pkg::word_t alu_res;
  rv_core_pkg::word_t result;
  rv_core_pkg::word_t link;
  rv_core_pkg::word_t jalr_target;
  logic [4:0] shamt;
  logic is_jal;
  logic is_jalr;
  logic is_branch;
  logic cond;
  logic we;

  assign opcode = i_x_inst[6:2];
  assign funct3 = i_x_inst[14:12];
  assign rd = i_x_inst[11:7];
  assign shamt = i_x_src2[4:0];

  assign is_jal = opcode == rv_core_pkg::opcode_jal;
  assign is_jalr = opcode == rv_core_pkg::opcode_jalr;
  assign is_branch = opcode == rv_core_pkg::opcode_branch;

  always_comb begin
    case (i_x_alu_op)
      rv_core_pkg::funct3_add: alu_res = i_x_alt ? i_x_src1 - i_x_src2 : i_x_src1 + i_x_src2;
      rv_core_pkg::funct3_sll: alu_res = i_x_src1 << shamt;
      rv_core_pkg::funct3_slt: alu_res = {{(rv_core_pkg::xlen-1){1'b0}},
                                          $signed(i_x_src1) < $signed(i_x_src2)};
      rv_core_pkg::funct3_sltu: alu_res = {{(rv_core_pkg::xlen-1){1'b0}}, i_x_src1 < i_x_src2};
      rv_core_pkg::funct3_xor: alu_res = i_x_src1 ^ i_x_src2;
      rv_core_pkg::funct3_sr: begin
        if (i_x_alt) begin
          alu_res = $signed(i_x_src1) >>> shamt;
        end else begin
          alu_res = i_x_src1 >> shamt;
        end
      end
      rv_core_pkg::funct3_or: alu_res = i_x_src1 | i_x_src2;
      default: alu_res = i_x_src1 & i_x_src2;
    endcase
  end

  // beq, bge and bgeu take on a zero compare result
  always_comb begin
    case (funct3)
      rv_core_pkg::funct3_beq,
      rv_core_pkg::funct3_bge,
      rv_core_pkg::funct3_bgeu: cond = (alu_res == '0);
      default: cond = (alu_res != '0);
    endcase
  end

  assign link = i_x_pc + 32'd4;
  assign jalr_target = (i_x_rs1 + i_x_imm) & ~32'd1;

  assign o_flush = i_x_valid & (is_jal | is_jalr | (is_branch & cond));
  assign o_target = is_jalr ? jalr_target : i_x_pc + i_x_imm;

  assign result = (is_jal | is_jalr) ? link : alu_res;
  assign we = i_x_valid && rv_core_pkg::writes_rd(opcode) && (rd != '0);

  always_ff @(posedge clk) begin
    if (!nrst) begin
      o_wb_en <= 1'b0;
      o_retire_valid <= 1'b0;
    end else begin
      o_wb_en <= we;
      o_retire_valid <= i_x_valid;
    end
  end

  // no write shows as rd 0 and data 0 on retire
  always_ff @(posedge clk) begin
    o_wb_addr <= we ? rd : '0;
    o_wb_data <= we ? result : '0;
    o_retire_pc <= i_x_pc;
  end

endmodule

//--- source/rv_fetch.sv
`timescale 1ns/10ps

module rv_fetch (
  input  logic               clk,
  input  logic               nrst,
  input  logic               i_running,
  input  logic               i_resume,
  input  rv_core_pkg::word_t i_resume_pc,
  input  logic               i_flush,
  input  rv_core_pkg::word_t i_target,
  input  rv_core_pkg::word_t i_wb_dat,
  input  logic               i_wb_ack,
  input  logic               i_d_ready,
  output logic               o_wb_cyc,
  output logic               o_wb_stb,
  output rv_core_pkg::word_t o_wb_adr,
  output logic               o_f_valid,
  output rv_core_pkg::word_t o_f_inst,
  output rv_core_pkg::word_t o_f_pc
);

  rv_core_pkg::word_t pc;
  logic discard;
  logic ack;
  logic start;

  assign ack = o_wb_cyc & i_wb_ack;

  // one transfer at a time, and only when the buffer is empty at the next edge,
  // so the ack of this cycle always finds room
  assign start = i_running & ~o_wb_cyc & ~i_flush & (~o_f_valid | i_d_ready);

  assign o_wb_stb = o_wb_cyc;

  always_ff @(posedge clk) begin
    if (!nrst) begin
      pc <= rv_core_pkg::reset_pc;
      o_wb_cyc <= 1'b0;
      discard <= 1'b0;
      o_f_valid <= 1'b0;
    end else begin
      if (i_resume) begin
        pc <= i_resume_pc;
      end else if (i_flush) begin
        pc <= i_target;
      end else if (start) begin
        pc <= pc + 32'd4;
      end

      if (start) begin
        o_wb_cyc <= 1'b1;
      end else if (ack) begin
        o_wb_cyc <= 1'b0;
      end

      // fetch still in flight at the flush, its word is dropped later
      if (i_flush && o_wb_cyc && !ack) begin
        discard <= 1'b1;
      end else if (ack) begin
        discard <= 1'b0;
      end

      if (i_flush) begin
        o_f_valid <= 1'b0;
      end else if (ack && !discard) begin
        o_f_valid <= 1'b1;
      end else if (i_d_ready) begin
        o_f_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      o_wb_adr <= pc;
    end
    if (ack) begin
      o_f_inst <= i_wb_dat;
      o_f_pc <= o_wb_adr;
    end
  end

endmodule

//--- source/rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile (
  input  logic                   clk,
  input  logic                   nrst,
  input  rv_core_pkg::reg_addr_t i_rs1_addr,
  input  rv_core_pkg::reg_addr_t i_rs2_addr,
  input  logic                   i_set_busy,
  input  rv_core_pkg::reg_addr_t i_busy_addr,
  input  logic                   i_wb_en,
  input  rv_core_pkg::reg_addr_t i_wb_addr,
  input  rv_core_pkg::word_t     i_wb_data,
  output rv_core_pkg::word_t     o_rs1_data,
  output rv_core_pkg::word_t     o_rs2_data,
  output logic                   o_rs1_busy,
  output logic                   o_rs2_busy
);

  rv_core_pkg::word_t regs [rv_core_pkg::n_regs];
  logic [rv_core_pkg::n_regs-1:0] busy;
  logic rs1_hit;
  logic rs2_hit;

  // write-first bypass from the writeback port
  assign rs1_hit = i_wb_en && (i_wb_addr == i_rs1_addr);
  assign rs2_hit = i_wb_en && (i_wb_addr == i_rs2_addr);

  assign o_rs1_data = (i_rs1_addr == '0) ? '0 : (rs1_hit ? i_wb_data : regs[i_rs1_addr]);
  assign o_rs2_data = (i_rs2_addr == '0) ? '0 : (rs2_hit ? i_wb_data : regs[i_rs2_addr]);
  assign o_rs1_busy = (i_rs1_addr != '0) && busy[i_rs1_addr] && !rs1_hit;
  assign o_rs2_busy = (i_rs2_addr != '0) && busy[i_rs2_addr] && !rs2_hit;

  always_ff @(posedge clk) begin
    if (i_wb_en) begin
      regs[i_wb_addr] <= i_wb_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      busy <= '0;
    end else begin
      if (i_wb_en) begin
        busy[i_wb_addr] <= 1'b0;
      end
      // a new writer of the same register wins over the clear
      if (i_set_busy) begin
        busy[i_busy_addr] <= 1'b1;
      end
    end
  end

endmodule

//--- tb.f
source/rv_core_pkg.sv
source/rv_fetch.sv
source/rv_decode.sv
source/rv_regfile.sv
source/rv_execute.sv
source/rv_core.sv
test/rv_core_props.sv
test/rv_core_checker.sv
test/tb_rv_core.sv

//--- test/rv_core_checker.sv
`timescale 1ns/10ps

module rv_core_checker #(
  parameter int mem_depth = 256
) (
  input  logic                   clk,
  input  logic                   nrst,
  input  int                     i_test_id,
  input  rv_core_pkg::word_t     i_mem [mem_depth],
  input  logic                   i_halted,
  input  logic                   i_resume_req,
  input  rv_core_pkg::word_t     i_resume_pc,
  input  logic                   i_retire_valid,
  input  rv_core_pkg::word_t     i_retire_pc,
  input  logic                   i_retire_we,
  input  rv_core_pkg::reg_addr_t i_retire_rd,
  input  rv_core_pkg::word_t     i_retire_data,
  output int                     o_errors,
  output int                     o_retires,
  output rv_core_pkg::word_t     o_ref_pc
);

  rv_core_pkg::word_t regs [32];
  rv_core_pkg::word_t inst;
  rv_core_pkg::word_t exp_data;
  rv_core_pkg::word_t exp_npc;
  rv_core_pkg::reg_addr_t exp_rd;
  logic exp_we;

  function automatic string test_name(int id);
    case (id)
      1: return "reset_idle";
      2: return "straight_alu";
      3: return "branch_jump";
      4: return "branch_jump_waits";
      default: return "halt_resume";
    endcase
  endfunction

  // architectural model of one instruction
  function automatic void ref_exec(input rv_core_pkg::word_t ins, input rv_core_pkg::word_t pc,
                                   input rv_core_pkg::word_t a, input rv_core_pkg::word_t b,
                                   output logic we, output rv_core_pkg::reg_addr_t rd,
                                   output rv_core_pkg::word_t data,
                                   output rv_core_pkg::word_t npc);
    logic [4:0] op;
    logic [2:0] f3;
    rv_core_pkg::word_t imm_i;
    rv_core_pkg::word_t imm_b;
    rv_core_pkg::word_t imm_j;
    rv_core_pkg::word_t opb;
    logic take;
    op = ins[6:2];
    f3 = ins[14:12];
    rd = ins[11:7];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    npc = pc + 4;
    data = '0;
    take = 1'b0;
    opb = (op == 5'b01100) ? b : imm_i;
    case (op)
      5'b01101: data = {ins[31:12], 12'h000};
      5'b00101: data = pc + {ins[31:12], 12'h000};
      5'b11011: begin
        data = pc + 4;
        npc = pc + imm_j;
      end
      5'b11001: begin
        data = pc + 4;
        npc = (a + imm_i) & ~32'd1;
      end
      5'b11000: begin
        case (f3)
          3'b000: take = (a == b);
          3'b001: take = (a != b);
          3'b100: take = ($signed(a) < $signed(b));
          3'b101: take = ($signed(a) >= $signed(b));
          3'b110: take = (a < b);
          default: take = (a >= b);
        endcase
        if (take) begin
          npc = pc + imm_b;
        end
      end
      default: begin
        case (f3)
          3'b000: data = (op == 5'b01100 && ins[30]) ? a - opb : a + opb;
          3'b001: data = a << opb[4:0];
          3'b010: data = ($signed(a) < $signed(opb)) ? 32'd1 : 32'd0;
          3'b011: data = (a < opb) ? 32'd1 : 32'd0;
          3'b100: data = a ^ opb;
          3'b101: begin
            if (ins[30]) begin
              data = $signed(a) >>> opb[4:0];
            end else begin
              data = a >> opb[4:0];
            end
          end
          3'b110: data = a | opb;
          default: data = a & opb;
        endcase
      end
    endcase
    we = (op != 5'b11000) && (rd != 0);
  endfunction

  task automatic compare(input string field, input rv_core_pkg::word_t exp,
                         input rv_core_pkg::word_t act);
    if (exp !== act) begin
      $display("[FAIL] %s: %s expected %h actual %h", test_name(i_test_id), field, exp, act);
      o_errors++;
    end
  endtask

  initial begin
    o_errors = 0;
    o_retires = 0;
    o_ref_pc = '0;
    foreach (regs[i]) regs[i] = '0;
  end

  always @(posedge clk) begin
    if (nrst && i_halted && i_resume_req) begin
      o_ref_pc = i_resume_pc;
    end else if (nrst && i_retire_valid) begin
      inst = i_mem[o_ref_pc[9:2]];
      ref_exec(inst, o_ref_pc, regs[inst[19:15]], regs[inst[24:20]],
               exp_we, exp_rd, exp_data, exp_npc);
      compare("pc", o_ref_pc, i_retire_pc);
      compare("we", 32'(exp_we), 32'(i_retire_we));
      if (exp_we) begin
        compare("rd", 32'(exp_rd), 32'(i_retire_rd));
        compare("data", exp_data, i_retire_data);
        regs[exp_rd] = exp_data;
      end
      o_ref_pc = exp_npc;
      o_retires++;
    end
  end

endmodule

//--- test/rv_core_props.sv
`timescale 1ns/10ps

module rv_core_props (
  input logic                   clk,
  input logic                   nrst,
  input logic                   o_wb_cyc,
  input logic                   o_wb_stb,
  input rv_core_pkg::word_t     o_wb_adr,
  input logic                   i_wb_ack,
  input logic                   o_retire_valid,
  input logic                   o_retire_we,
  input rv_core_pkg::reg_addr_t o_retire_rd
);

  a_stb_cyc: assert property (@(posedge clk) disable iff (!nrst) o_wb_stb |-> o_wb_cyc)
    else $error("wishbone stb high without cyc");

  // request held until the slave acks
  a_stb_hold: assert property (@(posedge clk) disable iff (!nrst)
    (o_wb_stb && !i_wb_ack) |=> (o_wb_stb && $stable(o_wb_adr)))
    else $error("wishbone stb or address changed before ack");

  a_reset_quiet: assert property (@(posedge clk) (!nrst && $past(!nrst)) |-> !o_retire_valid)
    else $error("retire seen during reset");

  a_we_rd: assert property (@(posedge clk) disable iff (!nrst)
    (o_retire_valid && o_retire_we) |-> (o_retire_rd != '0))
    else $error("retire write enable with rd x0");

endmodule

//--- test/tb_rv_core.sv
`timescale 1ns/10ps

module tb_rv_core;

  localparam int mem_depth = 256;
  localparam int n_prologue = 31;
  localparam int body_len = 60;
  localparam int end_idx = n_prologue + body_len;
  localparam int prog_words = end_idx + 1;
  localparam int total_instr = 8 * prog_words;
  localparam int timeout_limit = total_instr * 8 + 200;

  logic clk = 1'b0;
  logic nrst;
  rv_core_pkg::word_t i_wb_dat;
  logic i_wb_ack;
  logic i_halt_req;
  logic i_resume_req;
  rv_core_pkg::word_t i_resume_pc;
  logic o_wb_cyc;
  logic o_wb_stb;
  rv_core_pkg::word_t o_wb_adr;
  logic o_halted;
  logic o_retire_valid;
  rv_core_pkg::word_t o_retire_pc;
  logic o_retire_we;
  rv_core_pkg::reg_addr_t o_retire_rd;
  rv_core_pkg::word_t o_retire_data;

  rv_core_pkg::word_t mem [mem_depth];
  int seed = 36531;
  int max_wait = 0;
  int waits = 0;
  logic pending = 1'b0;
  int cycles = 0;
  int test_id = 0;
  int tb_errors = 0;
  int test_fails = 0;
  int err_base = 0;
  int ret_base = 0;
  int chk_errors;
  int chk_retires;
  rv_core_pkg::word_t ref_pc;
  rv_core_pkg::reg_addr_t last_rd = 5'd1;

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= timeout_limit) begin
      $display("run timed out after %0d cycles", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  // wishbone slave with 0 to max_wait wait states
  always @(negedge clk) begin
    if (i_wb_ack) begin
      i_wb_ack <= 1'b0;
      pending = 1'b0;
    end else if (o_wb_cyc && o_wb_stb) begin
      if (!pending) begin
        pending = 1'b1;
        waits = (max_wait == 0) ? 0 : rand_below(max_wait + 1);
      end
      if (waits == 0) begin
        i_wb_ack <= 1'b1;
        i_wb_dat <= mem[o_wb_adr[9:2]];
      end else begin
        waits--;
      end
    end
  end

  rv_core i_rv_core (.*);

  rv_core_checker #(.mem_depth(mem_depth)) i_checker (
    .clk(clk), .nrst(nrst), .i_test_id(test_id), .i_mem(mem), .i_halted(o_halted),
    .i_resume_req(i_resume_req), .i_resume_pc(i_resume_pc),
    .i_retire_valid(o_retire_valid), .i_retire_pc(o_retire_pc), .i_retire_we(o_retire_we),
    .i_retire_rd(o_retire_rd), .i_retire_data(o_retire_data),
    .o_errors(chk_errors), .o_retires(chk_retires), .o_ref_pc(ref_pc)
  );

  bind rv_core rv_core_props i_props (
    .clk(clk), .nrst(nrst), .o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_adr(o_wb_adr),
    .i_wb_ack(i_wb_ack), .o_retire_valid(o_retire_valid), .o_retire_we(o_retire_we),
    .o_retire_rd(o_retire_rd)
  );

  function automatic int rand_below(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic rv_core_pkg::word_t enc_i(logic [11:0] imm, logic [4:0] rs1,
                                               logic [2:0] f3, logic [4:0] rd, logic [4:0] op);
    return {imm, rs1, f3, rd, op, 2'b11};
  endfunction

  function automatic rv_core_pkg::word_t enc_b(logic [12:0] o, logic [4:0] rs2,
                                               logic [4:0] rs1, logic [2:0] f3);
    return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], rv_core_pkg::opcode_branch, 2'b11};
  endfunction

  function automatic rv_core_pkg::word_t enc_j(logic [20:0] o, logic [4:0] rd);
    return {o[20], o[10:1], o[11], o[19:12], rd, rv_core_pkg::opcode_jal, 2'b11};
  endfunction

  function automatic logic [4:0] pick_src();
    return (rand_below(2) == 0) ? last_rd : 5'(rand_below(32));
  endfunction

  task automatic emit_alu(input int idx);
    logic [2:0] f3;
    logic [4:0] rd;
    logic [11:0] imm;
    logic [6:0] f7;
    f3 = 3'(rand_below(8));
    rd = 5'(1 + rand_below(31));
    imm = 12'($random(seed));
    f7 = ((f3 == 3'd0 || f3 == 3'd5) && rand_below(2) == 1) ? 7'h20 : 7'h00;
    case (rand_below(4))
      0: mem[idx] = {f7, pick_src(), pick_src(), f3, rd, rv_core_pkg::opcode_op, 2'b11};
      1: begin
        if (f3 == 3'd1 || f3 == 3'd5) begin
          imm = {(f3 == 3'd5) ? f7 : 7'h00, imm[4:0]};
        end
        mem[idx] = enc_i(imm, pick_src(), f3, rd, rv_core_pkg::opcode_op_imm);
      end
      2: mem[idx] = {20'($random(seed)), rd, rv_core_pkg::opcode_lui, 2'b11};
      default: mem[idx] = {20'($random(seed)), rd, rv_core_pkg::opcode_auipc, 2'b11};
    endcase
    last_rd = rd;
  endtask

  // forward-only control flow, ends in a jal to itself
  task automatic gen_program(input bit with_flow);
    int i;
    int skip;
    int kind;
    logic [4:0] t;
    for (int a = 0; a < mem_depth; a++) begin
      mem[a] = enc_i(12'(a), 5'd0, 3'd0, 5'd0, rv_core_pkg::opcode_op_imm);
    end
    for (int r = 1; r <= n_prologue; r++) begin
      mem[r - 1] = enc_i(12'($random(seed)), 5'd0, 3'd0, 5'(r), rv_core_pkg::opcode_op_imm);
    end
    i = n_prologue;
    while (i < end_idx) begin
      kind = with_flow ? rand_below(8) : 0;
      skip = 1 + rand_below(3);
      if (kind == 5 && i + skip <= end_idx) begin
        mem[i] = enc_b(13'(skip * 4), pick_src(), pick_src(), 3'(rand_below(8)));
        if (mem[i][14:13] == 2'b01) begin
          mem[i][14:12] = 3'b000;
        end
      end else if (kind == 6 && i + skip <= end_idx) begin
        mem[i] = enc_j(21'(skip * 4), 5'(rand_below(32)));
      end else if (kind == 7 && i + 1 + skip <= end_idx) begin
        t = 5'(1 + rand_below(31));
        mem[i] = {20'd0, t, rv_core_pkg::opcode_auipc, 2'b11};
        i++;
        mem[i] = enc_i(12'((skip + 1) * 4 + rand_below(2)), t, 3'd0, 5'(rand_below(32)),
                       rv_core_pkg::opcode_jalr);
      end else begin
        emit_alu(i);
      end
      i++;
    end
    mem[end_idx] = enc_j(21'd0, 5'd0);
  endtask

  task automatic apply_reset();
    nrst = 1'b0;
    repeat (10) @(negedge clk);
    nrst = 1'b1;
  endtask

  task automatic resume_at(input rv_core_pkg::word_t pc);
    @(negedge clk);
    i_resume_req = 1'b1;
    i_resume_pc = pc;
    do @(negedge clk); while (o_halted);
    i_resume_req = 1'b0;
  endtask

  task automatic run_to_end();
    while (ref_pc != rv_core_pkg::word_t'(end_idx * 4)) @(negedge clk);
  endtask

  task automatic halt_and_drain();
    int quiet;
    quiet = 0;
    i_halt_req = 1'b1;
    while (!o_halted) @(negedge clk);
    i_halt_req = 1'b0;
    while (quiet < 10) begin
      @(negedge clk);
      quiet = o_retire_valid ? 0 : quiet + 1;
    end
  endtask

  task automatic start_test(input int id);
    test_id = id;
    err_base = chk_errors + tb_errors;
    ret_base = chk_retires;
  endtask

  task automatic end_test();
    int errs;
    errs = chk_errors + tb_errors - err_base;
    $display("test %0d: %0d retired, %0d errors", test_id, chk_retires - ret_base, errs);
    if (errs != 0) begin
      test_fails++;
    end
  endtask

  initial begin
    int bad;
    nrst = 1'b0;
    i_wb_ack = 1'b0;
    i_wb_dat = '0;
    i_halt_req = 1'b0;
    i_resume_req = 1'b0;
    i_resume_pc = '0;
    gen_program(1'b0);

    start_test(1);
    apply_reset();
    bad = 0;
    repeat (20) begin
      @(negedge clk);
      if (!o_halted || o_wb_cyc || o_retire_valid) begin
        bad++;
      end
    end
    if (bad != 0) begin
      $display("reset_idle: core did not stay halted and idle after reset");
      tb_errors++;
    end
    end_test();

    for (int t = 2; t <= 4; t++) begin
      start_test(t);
      if (t == 3) begin
        gen_program(1'b1);
      end
      max_wait = (t == 4) ? 3 : 0;
      apply_reset();
      resume_at('0);
      run_to_end();
      halt_and_drain();
      end_test();
    end

    start_test(5);
    gen_program(1'b1);
    apply_reset();
    resume_at('0);
    while (chk_retires - ret_base < 50) @(negedge clk);
    halt_and_drain();
    bad = chk_retires;
    repeat (20) @(negedge clk);
    if (chk_retires != bad || !o_halted) begin
      $display("halt_resume: core retired instructions while halted");
      tb_errors++;
    end
    resume_at(rv_core_pkg::word_t'(n_prologue * 4));
    run_to_end();
    halt_and_drain();
    end_test();

    $display("passed %0d, failed %0d", 5 - test_fails, test_fails);
    if (test_fails == 0 && chk_errors == 0 && tb_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
